/* src/cam_pkg.sv */
package cam_pkg;

  // Stored word and search key width.
  localparam int WORD_W = 22;

  // Largest entry count the address field can reach.
  localparam int MAX_ENTRY = 64;

  // Address width, enough for MAX_ENTRY entries.
  localparam int ADDR_W = $clog2(MAX_ENTRY);

  // Entry count used when the top level is not overridden.
  localparam int DEFAULT_ENTRY = 50;

  // One stored word, or one search key.
  typedef logic [WORD_W-1:0] cam_word_t;

  // One entry address.
  typedef logic [ADDR_W-1:0] cam_addr_t;

  // Write request, qualified by a separate strobe.
  typedef struct packed {
    cam_addr_t addr; // Target entry.
    cam_word_t data; // Word to store there.
  } cam_write_t;

  // Search answer.
  // Only meaningful while result_valid is high.
  typedef struct packed {
    logic      hit;  // Some valid entry matched the key.
    cam_addr_t addr; // Lowest matching entry, zero on a miss.
  } cam_result_t;

endpackage

/* src/cam_ctrl.sv */
`timescale 1ns/1ps

module cam_ctrl #(
  parameter int NUM_ENTRY = cam_pkg::DEFAULT_ENTRY
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 write_valid,
  input  cam_pkg::cam_addr_t   write_addr,
  input  logic                 search_valid,
  output logic [NUM_ENTRY-1:0] write_sel,
  output logic                 write_error,
  output logic                 compare_go,
  output logic                 encode_go,
  output logic                 result_valid
);

  import cam_pkg::*;

  logic addr_in_range; // Write address names an existing entry.

  // The entry count need not be a power of two.
  // Codes at or above NUM_ENTRY exist on the bus but have no entry behind them.
  assign addr_in_range = (int'(write_addr) < NUM_ENTRY);

  // One-hot write select.
  // An out-of-range address matches no index, so no entry is touched.
  for (genvar i = 0; i < NUM_ENTRY; i++) begin : g_write_sel
    assign write_sel[i] = write_valid && (write_addr == cam_addr_t'(i));
  end

  // Error pulse one cycle after a rejected write.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      write_error <= 1'b0;
    end else begin
      write_error <= write_valid && !addr_in_range; // High for one cycle only.
    end
  end

  // Search strobe pipeline.
  // Stage 0 is the strobe itself, it loads the match register in cycle N.
  assign compare_go = search_valid;

  // Stage 1 loads the encoder register, stage 2 flags the result.
  // Each search walks the chain alone, so two may be in flight.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      encode_go    <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      encode_go    <= compare_go; // Match vector valid in N+1.
      result_valid <= encode_go;  // Encoded result valid in N+2.
    end
  end

endmodule

/* src/cam_entry_array.sv */
`timescale 1ns/1ps

module cam_entry_array #(
  parameter int NUM_ENTRY = cam_pkg::DEFAULT_ENTRY
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [NUM_ENTRY-1:0] write_sel,
  input  cam_pkg::cam_word_t   write_data,
  input  logic                 compare_go,
  input  cam_pkg::cam_word_t   search_key,
  output logic [NUM_ENTRY-1:0] match_vec
);

  import cam_pkg::*;

  cam_word_t            entry_word [NUM_ENTRY]; // Stored words.
  logic [NUM_ENTRY-1:0] entry_valid;            // Entry has been written since reset.
  logic [NUM_ENTRY-1:0] match_next;             // Live compare result.

  // Word storage.
  // At most one select bit is high.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        entry_word[i] <= '0; // Zero words stay hidden behind clear valid bits.
      end
    end else begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        if (write_sel[i]) begin
          entry_word[i] <= write_data; // Overwrite replaces the old word.
        end
      end
    end
  end

  // Valid bits.
  // Set on first write and never cleared.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      entry_valid <= '0;
    end else begin
      entry_valid <= entry_valid | write_sel;
    end
  end

  // Parallel compare of the key against every entry.
  // This reads the pre-write contents, so a search beside a write sees old data.
  always_comb begin
    for (int i = 0; i < NUM_ENTRY; i++) begin
      match_next[i] = entry_valid[i] && (entry_word[i] == search_key);
    end
  end

  // Match register, loaded at the end of the search cycle.
  // It holds its value between searches.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      match_vec <= '0;
    end else if (compare_go) begin
      match_vec <= match_next; // One bit per entry.
    end
  end

endmodule

/* src/match_encoder.sv */
`timescale 1ns/1ps

module match_encoder #(
  parameter int NUM_ENTRY = cam_pkg::DEFAULT_ENTRY
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 encode_go,
  input  logic [NUM_ENTRY-1:0] match_vec,
  output cam_pkg::cam_result_t result
);

  import cam_pkg::*;

  cam_result_t result_next; // Encoded form of the current match vector.

  // Lowest-index priority encoder.
  always_comb begin
    result_next.hit  = |match_vec; // Any entry matched.
    result_next.addr = '0;         // Miss reports address zero.
    // Walk down from the top.
    // The last set bit seen is the lowest, and it wins.
    for (int i = NUM_ENTRY - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        result_next.addr = cam_addr_t'(i);
      end
    end
  end

  // Result register, loaded one cycle after the match register.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (encode_go) begin
      result <= result_next; // Seen in N+2 with result_valid.
    end
  end

endmodule

/* src/cam_top.sv */
`timescale 1ns/1ps

module cam_top #(
  parameter int NUM_ENTRY = cam_pkg::DEFAULT_ENTRY
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 write_valid,
  input  cam_pkg::cam_write_t  write_req,
  input  logic                 search_valid,
  input  cam_pkg::cam_word_t   search_key,
  output logic                 result_valid,
  output cam_pkg::cam_result_t result,
  output logic                 write_error
);

  logic [NUM_ENTRY-1:0] write_sel;  // One-hot, in-range writes only.
  logic                 compare_go; // Loads the match register.
  logic                 encode_go;  // Loads the result register.
  logic [NUM_ENTRY-1:0] match_vec;  // Registered compare result.

  // Controller.
  // Judges the write address and sequences the search stages.
  cam_ctrl #(
    .NUM_ENTRY    (NUM_ENTRY)
  ) i_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .write_valid  (write_valid),
    .write_addr   (write_req.addr), // Address field only.
    .search_valid (search_valid),
    .write_sel    (write_sel),
    .write_error  (write_error),
    .compare_go   (compare_go),
    .encode_go    (encode_go),
    .result_valid (result_valid)
  );

  // Storage and parallel compare.
  cam_entry_array #(
    .NUM_ENTRY  (NUM_ENTRY)
  ) i_array (
    .clk        (clk),
    .arst_n     (arst_n),
    .write_sel  (write_sel),
    .write_data (write_req.data), // Data field only.
    .compare_go (compare_go),
    .search_key (search_key),
    .match_vec  (match_vec)
  );

  // Priority encoder, second pipeline stage.
  match_encoder #(
    .NUM_ENTRY (NUM_ENTRY)
  ) i_encoder (
    .clk       (clk),
    .arst_n    (arst_n),
    .encode_go (encode_go),
    .match_vec (match_vec),
    .result    (result)
  );

endmodule

/* verification/cam_props.sv */
`timescale 1ns/1ps

module cam_props (
  input logic clk,
  input logic arst_n,
  input logic write_valid,
  input logic search_valid,
  input logic result_valid,
  input logic write_error
);

  // Every search strobe is answered exactly two cycles later.
  property p_search_answered;
    @(posedge clk) disable iff (!arst_n) search_valid |-> ##2 result_valid;
  endproperty

  // No result appears without a search two cycles before.
  property p_result_has_search;
    @(posedge clk) disable iff (!arst_n) result_valid |-> $past(search_valid, 2);
  endproperty

  // An error pulse always follows a write strobe.
  property p_error_after_write;
    @(posedge clk) disable iff (!arst_n) write_error |-> $past(write_valid);
  endproperty

  // Result strobe held low while in reset.
  property p_quiet_in_reset;
    @(posedge clk) !arst_n |-> !result_valid;
  endproperty

  a_search_answered: assert property (p_search_answered)
    else $error("Search strobe not followed by result_valid two cycles later.");
  a_result_has_search: assert property (p_result_has_search)
    else $error("result_valid high without a search two cycles earlier.");
  a_error_after_write: assert property (p_error_after_write)
    else $error("write_error high without a write strobe in the cycle before.");
  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else $error("result_valid high during reset.");

endmodule

// Attach the checks to every CAM top level.
bind cam_top cam_props i_props (
  .clk          (clk),
  .arst_n       (arst_n),
  .write_valid  (write_valid),
  .search_valid (search_valid),
  .result_valid (result_valid),
  .write_error  (write_error)
);

/* verification/cam_tb.sv */
`timescale 1ns/1ps

module cam_tb;

  import cam_pkg::*;

  localparam int NUM_ENTRY    = 50;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  // All tests together take under 100 cycles.
  localparam int MAX_CYCLES   = 2000;
  localparam int RAND_WRITES  = 10;

  logic        clk;
  logic        arst_n;
  logic        write_valid;
  cam_write_t  write_req;
  logic        search_valid;
  cam_word_t   search_key;
  logic        result_valid;
  cam_result_t result;
  logic        write_error;

  cam_word_t   model_word [NUM_ENTRY]; // Reference copy of the stored words.
  bit          model_valid [NUM_ENTRY];
  cam_result_t exp_res_q [$];          // Pending search answers, oldest first.
  int          exp_due_q [$];          // Cycle in which each answer is due.
  string       exp_name_q [$];
  bit          err_pending;            // Error pulse due next cycle.
  int          cycle;
  int          errors;
  int          run_cycles = 0;
  string       test_name;
  cam_word_t   prio_word;              // Shared by the priority and later tests.
  cam_word_t   new_word;

  cam_top #(
    .NUM_ENTRY    (NUM_ENTRY)
  ) i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .write_valid  (write_valid),
    .write_req    (write_req),
    .search_valid (search_valid),
    .search_key   (search_key),
    .result_valid (result_valid),
    .result       (result),
    .write_error  (write_error)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog on a stuck run.
  initial begin
    while (run_cycles < MAX_CYCLES) begin
      @(posedge clk);
      run_cycles++;
    end
    $display("Timeout, run did not finish within %0d cycles.", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  // Lowest valid entry holding the key.
  // A miss reports address zero.
  function automatic cam_result_t model_search(cam_word_t key);
    cam_result_t res;
    res = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (!res.hit && model_valid[i] && model_word[i] == key) begin
        res.hit  = 1'b1;
        res.addr = cam_addr_t'(i);
      end
    end
    return res;
  endfunction

  // Random word that no valid entry holds.
  function automatic cam_word_t fresh_word();
    cam_word_t   w;
    cam_result_t probe;
    w     = cam_word_t'($urandom());
    probe = model_search(w);
    while (probe.hit) begin
      w     = cam_word_t'($urandom());
      probe = model_search(w);
    end
    return w;
  endfunction

  task automatic check_outputs();
    bit          exp_rv;
    cam_result_t exp_res;
    string       name;
    exp_rv = (exp_due_q.size() > 0) && (exp_due_q[0] == cycle);
    assert (result_valid === exp_rv) else begin
      $display("[FAIL] %s: result_valid expected %0b actual %0b", test_name, exp_rv,
               result_valid);
      errors++;
    end
    if (exp_rv) begin
      exp_res = exp_res_q.pop_front();
      name    = exp_name_q.pop_front();
      void'(exp_due_q.pop_front());
      if (result_valid === 1'b1) begin
        assert (result === exp_res) else begin
          $display("[FAIL] %s: result expected hit=%0b addr=%0d actual hit=%0b addr=%0d",
                   name, exp_res.hit, exp_res.addr, result.hit, result.addr);
          errors++;
        end
      end
    end
    assert (write_error === err_pending) else begin
      $display("[FAIL] %s: write_error expected %0b actual %0b", test_name, err_pending,
               write_error);
      errors++;
    end
    err_pending = 1'b0;
  endtask

  // Advance one cycle, check outputs, then drop the strobes.
  task automatic tick();
    @(posedge clk);
    #2;
    cycle++;
    check_outputs();
    write_valid  = 1'b0;
    search_valid = 1'b0;
  endtask

  // One cycle of stimulus.
  // The search sees the model before this cycle's write.
  task automatic issue(bit do_write, cam_addr_t addr, cam_word_t data,
                       bit do_search, cam_word_t key);
    if (do_search) begin
      search_valid = 1'b1;
      search_key   = key;
      exp_res_q.push_back(model_search(key));
      exp_due_q.push_back(cycle + 2); // Fixed two-cycle latency.
      exp_name_q.push_back(test_name);
    end
    if (do_write) begin
      write_valid    = 1'b1;
      write_req.addr = addr;
      write_req.data = data;
      if (int'(addr) < NUM_ENTRY) begin
        model_word[addr]  = data;
        model_valid[addr] = 1'b1;
      end else begin
        err_pending = 1'b1; // Rejected write leaves contents unchanged.
      end
    end
    tick();
  endtask

  task automatic write_word(cam_addr_t addr, cam_word_t data);
    issue(1'b1, addr, data, 1'b0, '0);
  endtask

  task automatic search_word(cam_word_t key);
    issue(1'b0, '0, '0, 1'b1, key);
  endtask

  // Wait until every outstanding answer and error pulse was checked.
  task automatic drain();
    while (exp_due_q.size() > 0 || err_pending) begin
      tick();
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    search_word('0); // Zero contents must not match.
    drain();
  endtask

  task automatic test_write_search();
    cam_word_t words [RAND_WRITES];
    cam_addr_t addr;
    test_name = "write_search";
    for (int i = 0; i < RAND_WRITES; i++) begin
      addr = cam_addr_t'($urandom_range(NUM_ENTRY - 1));
      while (model_valid[addr]) begin
        addr = cam_addr_t'($urandom_range(NUM_ENTRY - 1)); // Distinct entries.
      end
      words[i] = fresh_word();
      write_word(addr, words[i]);
    end
    for (int i = 0; i < RAND_WRITES; i++) begin
      search_word(words[i]);
    end
    search_word(fresh_word()); // A key never written must miss.
    drain();
  endtask

  task automatic test_priority();
    test_name = "priority";
    prio_word = fresh_word();
    write_word(6'd37, prio_word);
    write_word(6'd12, prio_word);
    write_word(6'd40, prio_word);
    search_word(prio_word); // Lowest index wins.
    drain();
  endtask

  task automatic test_overwrite();
    test_name = "overwrite";
    new_word = fresh_word();
    write_word(6'd12, new_word);
    search_word(prio_word); // Old word now first at 37.
    search_word(new_word);
    drain();
  endtask

  task automatic test_back_to_back();
    cam_word_t late_word;
    test_name = "back_to_back";
    late_word = fresh_word();
    search_word(prio_word);
    search_word(new_word);
    search_word(fresh_word());
    search_word(model_word[37]);
    issue(1'b1, 6'd5, late_word, 1'b1, late_word); // Sees pre-write contents.
    search_word(late_word);
    drain();
  endtask

  task automatic test_out_of_range();
    cam_word_t lost_word;
    test_name = "out_of_range";
    lost_word = fresh_word();
    write_word(6'd55, lost_word); // No entry 55 with 50 entries.
    search_word(lost_word);
    drain();
  endtask

  initial begin
    int seed;
    seed         = $urandom(98048);
    arst_n       = 1'b0;
    write_valid  = 1'b0;
    write_req    = '0;
    search_valid = 1'b0;
    search_key   = '0;
    err_pending  = 1'b0;
    cycle        = 0;
    errors       = 0;
    test_name    = "init";
    for (int i = 0; i < NUM_ENTRY; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (RESET_CYCLES) tick();
    arst_n = 1'b1;
    tick();
    test_reset();
    test_write_search();
    test_priority();
    test_overwrite();
    test_back_to_back();
    test_out_of_range();
    repeat (4) tick(); // Quiet tail without strobes.
    $display("Checks done after %0d cycles, errors: %0d", cycle, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* cam_top.f */
src/cam_pkg.sv
src/cam_ctrl.sv
src/cam_entry_array.sv
src/match_encoder.sv
src/cam_top.sv
verification/cam_props.sv
verification/cam_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CAM testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cam_tb -f cam_top.f

sim_out=$(./obj_dir/Vcam_tb)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi
